//--- copp_video_pkg.sv
package copp_video_pkg;

    // Beam coordinate width, shared by both axes
    localparam int COORD_W = 11;

    typedef logic [COORD_W-1:0] coord_t;

    // Shortened raster so a frame passes quickly in simulation
    // Counts cover visible area plus all blanking
    localparam coord_t H_TOTAL = 11'd80;
    localparam coord_t V_TOTAL = 11'd24;

    // Pixels before end of last line where the copper restarts
    localparam coord_t RESTART_LEAD = 11'd5;

    // Restart position, on the last line of vertical blanking
    localparam coord_t RESTART_H = H_TOTAL - RESTART_LEAD;
    localparam coord_t RESTART_V = V_TOTAL - 11'd1;

endpackage

//--- copp_isa_pkg.sv
package copp_isa_pkg;

    // Instruction index into both program banks
    localparam int PC_W = 10;

    typedef logic [PC_W-1:0] pc_t;

    // Opcode lives in bits [31:28] of the instruction
    typedef enum logic [3:0] {
        OP_WAIT  = 4'b0000,
        OP_SKIP  = 4'b0010,
        OP_JMP   = 4'b0100,
        OP_MOVER = 4'b1001,
        OP_MOVEF = 4'b1010,
        OP_MOVEP = 4'b1011
    } opcode_t;

    typedef enum logic [2:0] {
        ST_INIT    = 3'b000,
        ST_FETCH   = 3'b001,
        ST_LATCH   = 3'b010,
        ST_EXEC    = 3'b011,
        ST_EX_WAIT = 3'b100,
        ST_EX_SKIP = 3'b101
    } seq_state_t;

    // Control register, enable in bit 15, initial index in low bits
    localparam int CTRL_EN_BIT = 15;

    typedef struct packed {
        logic en;
        pc_t  init_pc;
    } copp_ctrl_t;

    // XR register number and memory windows
    localparam logic [3:0]  XR_COPP_CTRL = 4'h1;
    localparam logic [15:0] XR_TILE_MEM  = 16'h4000;
    localparam logic [15:0] XR_COLOR_MEM = 16'h8000;

    // WAIT / SKIP flag bits in the second word
    localparam int FLAG_IGNORE_V = 0;
    localparam int FLAG_IGNORE_H = 1;

endpackage

//--- copp_bank_if.sv
`default_nettype none
`timescale 1ns/1ps

interface copp_bank_if;

    // Write side, driven from the host port
    logic                    wr_en;
    copp_isa_pkg::pc_t       wr_addr;
    logic [15:0]             wr_data;

    // Read side, driven from the sequencer
    logic                    rd_en;
    copp_isa_pkg::pc_t       rd_addr;
    // Valid the cycle after rd_en, held until the next read
    logic [15:0]             rd_data;

    modport host_mp (output wr_en, output wr_addr, output wr_data);

    modport seq_mp (output rd_en, output rd_addr, input rd_data);

    modport bank_mp (
        input  wr_en, input wr_addr, input wr_data,
        input  rd_en, input rd_addr,
        output rd_data
    );

endinterface

`default_nettype wire

//--- copp_host_port.sv
`default_nettype none
`timescale 1ns/1ps

module copp_host_port (
    input  wire logic                         clk,
    input  wire logic                         copp_reset,
    input  wire logic                         reg_wr_i,
    input  wire logic [3:0]                   reg_num_i,
    input  wire logic [15:0]                  reg_data_i,
    input  wire logic                         mem_wr_i,
    input  wire logic [copp_isa_pkg::PC_W:0]  mem_addr_i,
    input  wire logic [15:0]                  mem_data_i,
    output copp_isa_pkg::copp_ctrl_t          ctrl_o,
    copp_bank_if.host_mp                      banks [2]
);

    logic              bank_sel;
    copp_isa_pkg::pc_t wr_index;

    // Control register, cleared to disabled with index 0
    always_ff @(posedge clk) begin
        if (copp_reset) begin
            ctrl_o <= '0;
        end else if (reg_wr_i && (reg_num_i == copp_isa_pkg::XR_COPP_CTRL)) begin
            ctrl_o.en      <= reg_data_i[copp_isa_pkg::CTRL_EN_BIT];
            // Reserved bits between enable and index are dropped
            ctrl_o.init_pc <= reg_data_i[copp_isa_pkg::PC_W-1:0];
        end
    end

    // Address bit 0 picks even or odd word
    assign bank_sel = mem_addr_i[0];
    // Upper bits give the instruction index
    assign wr_index = mem_addr_i[copp_isa_pkg::PC_W:1];

    // Steer the strobe to one bank, address and data go to both
    for (genvar g = 0; g < 2; g++) begin : g_bank
        assign banks[g].wr_en   = mem_wr_i && (bank_sel == 1'(g));
        assign banks[g].wr_addr = wr_index;
        assign banks[g].wr_data = mem_data_i;
    end

endmodule

`default_nettype wire

//--- copp_mem_bank.sv
`default_nettype none
`timescale 1ns/1ps

module copp_mem_bank (
    input  wire logic     clk,
    copp_bank_if.bank_mp  mem
);

    // One 16-bit word per instruction index
    logic [15:0] ram [2**copp_isa_pkg::PC_W];

    // Host write lands on the same edge as the strobe
    always_ff @(posedge clk) begin
        if (mem.wr_en) begin
            ram[mem.wr_addr] <= mem.wr_data;
        end
    end

    // Registered read, one cycle latency
    // Output holds between reads
    always_ff @(posedge clk) begin
        if (mem.rd_en) begin
            mem.rd_data <= ram[mem.rd_addr];
        end
    end

endmodule

`default_nettype wire

//--- copp_sequencer.sv
`default_nettype none
`timescale 1ns/1ps

module copp_sequencer (
    input  wire logic                     clk,
    input  wire logic                     copp_reset,
    input  wire copp_isa_pkg::copp_ctrl_t ctrl_i,
    input  wire copp_video_pkg::coord_t   h_count_i,
    input  wire copp_video_pkg::coord_t   v_count_i,
    copp_bank_if.seq_mp                   banks [2],
    output logic                          xr_wr_en_o,
    output logic [15:0]                   xr_wr_addr_o,
    output logic [15:0]                   xr_wr_data_o
);

    copp_isa_pkg::seq_state_t state;
    copp_isa_pkg::pc_t        pc;
    copp_isa_pkg::opcode_t    insn_op;
    logic                     rd_strobe;
    logic [31:0]              insn;
    logic                     v_reached;
    logic                     h_reached;
    logic                     ign_v;
    logic                     ign_h;
    logic                     pos_hit;
    logic                     frame_restart;
    logic [15:0]              rd_word [2];

    // Restart point near the end of vertical blanking
    assign frame_restart = (h_count_i == copp_video_pkg::RESTART_H) &&
                           (v_count_i == copp_video_pkg::RESTART_V);

    // Decode fields of the latched instruction
    assign insn_op = copp_isa_pkg::opcode_t'(insn[31:28]);
    assign ign_v   = insn[copp_isa_pkg::FLAG_IGNORE_V];
    assign ign_h   = insn[copp_isa_pkg::FLAG_IGNORE_H];

    // Reached on every axis not ignored
    assign pos_hit = (ign_v || v_reached) && (ign_h || h_reached);

    // Both banks read the same index
    for (genvar g = 0; g < 2; g++) begin : g_bank
        assign banks[g].rd_en   = rd_strobe;
        assign banks[g].rd_addr = pc;
        assign rd_word[g]       = banks[g].rd_data;
    end

    always_ff @(posedge clk) begin
        if (copp_reset) begin
            state      <= copp_isa_pkg::ST_INIT;
            pc         <= '0;
            rd_strobe  <= 1'b0;
            xr_wr_en_o <= 1'b0;
        end else if (frame_restart) begin
            // New frame, reload the start index
            state      <= copp_isa_pkg::ST_INIT;
            pc         <= ctrl_i.init_pc;
            rd_strobe  <= 1'b0;
            xr_wr_en_o <= 1'b0;
        end else begin
            // Strobes last a single cycle
            rd_strobe  <= 1'b0;
            xr_wr_en_o <= 1'b0;

            case (state)
                copp_isa_pkg::ST_INIT: begin
                    // Idle here until enabled
                    if (ctrl_i.en) begin
                        state     <= copp_isa_pkg::ST_FETCH;
                        rd_strobe <= 1'b1;
                    end
                end
                copp_isa_pkg::ST_FETCH: begin
                    // Read is in flight this cycle
                    if (ctrl_i.en) begin
                        state <= copp_isa_pkg::ST_LATCH;
                    end else begin
                        state <= copp_isa_pkg::ST_INIT;
                    end
                end
                copp_isa_pkg::ST_LATCH: begin
                    // Even bank gives the first word
                    insn  <= {rd_word[0], rd_word[1]};
                    state <= copp_isa_pkg::ST_EXEC;
                end
                copp_isa_pkg::ST_EXEC: begin
                    case (insn_op)
                        copp_isa_pkg::OP_WAIT: begin
                            // Y in [26:16], X in [14:4]
                            v_reached <= v_count_i >= insn[26:16];
                            h_reached <= h_count_i >= insn[14:4];
                            state     <= copp_isa_pkg::ST_EX_WAIT;
                        end
                        copp_isa_pkg::OP_SKIP: begin
                            v_reached <= v_count_i >= insn[26:16];
                            h_reached <= h_count_i >= insn[14:4];
                            state     <= copp_isa_pkg::ST_EX_SKIP;
                        end
                        copp_isa_pkg::OP_JMP: begin
                            pc        <= insn[25:16];
                            state     <= copp_isa_pkg::ST_FETCH;
                            rd_strobe <= 1'b1;
                        end
                        copp_isa_pkg::OP_MOVER: begin
                            // Zero-extended register number
                            xr_wr_en_o   <= 1'b1;
                            xr_wr_addr_o <= {8'h00, insn[23:16]};
                            xr_wr_data_o <= insn[15:0];
                            pc           <= pc + 1'b1;
                            state        <= copp_isa_pkg::ST_FETCH;
                            rd_strobe    <= 1'b1;
                        end
                        copp_isa_pkg::OP_MOVEF: begin
                            // 12-bit tile memory offset
                            xr_wr_en_o   <= 1'b1;
                            xr_wr_addr_o <= copp_isa_pkg::XR_TILE_MEM + {4'h0, insn[27:16]};
                            xr_wr_data_o <= insn[15:0];
                            pc           <= pc + 1'b1;
                            state        <= copp_isa_pkg::ST_FETCH;
                            rd_strobe    <= 1'b1;
                        end
                        copp_isa_pkg::OP_MOVEP: begin
                            // 8-bit palette index
                            xr_wr_en_o   <= 1'b1;
                            xr_wr_addr_o <= copp_isa_pkg::XR_COLOR_MEM + {8'h00, insn[23:16]};
                            xr_wr_data_o <= insn[15:0];
                            pc           <= pc + 1'b1;
                            state        <= copp_isa_pkg::ST_FETCH;
                            rd_strobe    <= 1'b1;
                        end
                        default: begin
                            // Illegal opcode, acts as a NOP
                            pc        <= pc + 1'b1;
                            state     <= copp_isa_pkg::ST_FETCH;
                            rd_strobe <= 1'b1;
                        end
                    endcase
                end
                copp_isa_pkg::ST_EX_WAIT: begin
                    // Both axes ignored means wait for next frame
                    if (!(ign_v && ign_h) && pos_hit) begin
                        pc        <= pc + 1'b1;
                        state     <= copp_isa_pkg::ST_FETCH;
                        rd_strobe <= 1'b1;
                    end else begin
                        state <= copp_isa_pkg::ST_EXEC;
                    end
                end
                copp_isa_pkg::ST_EX_SKIP: begin
                    // Pass over the next instruction when reached
                    if (pos_hit) begin
                        pc <= pc + copp_isa_pkg::pc_t'(2);
                    end else begin
                        pc <= pc + copp_isa_pkg::pc_t'(1);
                    end
                    state     <= copp_isa_pkg::ST_FETCH;
                    rd_strobe <= 1'b1;
                end
                default: begin
                    state <= copp_isa_pkg::ST_INIT;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- copper.sv
`default_nettype none
`timescale 1ns/1ps

module copper (
    input  wire logic                         clk,
    input  wire logic                         copp_reset,
    // Host control-register write
    input  wire logic                         reg_wr_i,
    input  wire logic [3:0]                   reg_num_i,
    input  wire logic [15:0]                  reg_data_i,
    // Host program write, bit 0 selects the bank
    input  wire logic                         mem_wr_i,
    input  wire logic [copp_isa_pkg::PC_W:0]  mem_addr_i,
    input  wire logic [15:0]                  mem_data_i,
    // Beam position
    input  wire copp_video_pkg::coord_t       h_count_i,
    input  wire copp_video_pkg::coord_t       v_count_i,
    // XR register write
    output logic                              xr_wr_en_o,
    output logic [15:0]                       xr_wr_addr_o,
    output logic [15:0]                       xr_wr_data_o
);

    copp_isa_pkg::copp_ctrl_t ctrl;

    // Bank 0 holds first words, bank 1 second words
    copp_bank_if banks [2] ();

    copp_host_port i_host_port (
        .clk        (clk),
        .copp_reset (copp_reset),
        .reg_wr_i   (reg_wr_i),
        .reg_num_i  (reg_num_i),
        .reg_data_i (reg_data_i),
        .mem_wr_i   (mem_wr_i),
        .mem_addr_i (mem_addr_i),
        .mem_data_i (mem_data_i),
        .ctrl_o     (ctrl),
        .banks      (banks)
    );

    for (genvar g = 0; g < 2; g++) begin : g_mem
        copp_mem_bank i_mem_bank (
            .clk (clk),
            .mem (banks[g])
        );
    end

    copp_sequencer i_sequencer (
        .clk          (clk),
        .copp_reset   (copp_reset),
        .ctrl_i       (ctrl),
        .h_count_i    (h_count_i),
        .v_count_i    (v_count_i),
        .banks        (banks),
        .xr_wr_en_o   (xr_wr_en_o),
        .xr_wr_addr_o (xr_wr_addr_o),
        .xr_wr_data_o (xr_wr_data_o)
    );

endmodule

`default_nettype wire

//--- copper_properties.sv
`timescale 1ns/1ps

module copper_properties (
    input logic                     clk,
    input logic                     copp_reset,
    input logic                     xr_wr_en_o,
    input logic                     rd_en,
    input copp_isa_pkg::seq_state_t state
);

    // Count of failed assertions
    int err_cnt = 0;

    // XR write is a single-cycle pulse
    assert property (@(posedge clk) disable iff (copp_reset)
        xr_wr_en_o |=> !xr_wr_en_o)
    else begin
        err_cnt++;
        $error("xr_wr_en_o high on two consecutive cycles");
    end

    // Read strobe only alongside a fetch
    assert property (@(posedge clk) disable iff (copp_reset)
        rd_en |-> (state == copp_isa_pkg::ST_INIT || state == copp_isa_pkg::ST_FETCH))
    else begin
        err_cnt++;
        $error("rd_en high outside fetch");
    end

    // FSM stays on a legal encoding
    assert property (@(posedge clk) disable iff (copp_reset)
        state inside {copp_isa_pkg::ST_INIT, copp_isa_pkg::ST_FETCH, copp_isa_pkg::ST_LATCH,
                      copp_isa_pkg::ST_EXEC, copp_isa_pkg::ST_EX_WAIT,
                      copp_isa_pkg::ST_EX_SKIP})
    else begin
        err_cnt++;
        $error("sequencer state not legal");
    end

endmodule

bind copp_sequencer copper_properties i_copper_properties (
    .clk        (clk),
    .copp_reset (copp_reset),
    .xr_wr_en_o (xr_wr_en_o),
    .rd_en      (rd_strobe),
    .state      (state)
);

//--- tb_copper.sv
`timescale 1ns/1ps

module tb_copper;

    localparam int MAX_WR = 32;
    localparam int LIMIT = 8 * int'(copp_video_pkg::H_TOTAL) * int'(copp_video_pkg::V_TOTAL)
                           + 200;
    localparam int MODE_NONE = 2;

    logic clk = 1'b0;
    logic copp_reset, reg_wr_i, mem_wr_i, xr_wr_en_o;
    logic [3:0] reg_num_i;
    logic [15:0] reg_data_i, mem_data_i, xr_wr_addr_o, xr_wr_data_o;
    logic [10:0] mem_addr_i;
    // Beam sits at the origin until the first reset edge
    copp_video_pkg::coord_t h_count = '0;
    copp_video_pkg::coord_t v_count = '0;

    // Predicted writes per program with 0 for A and 1 for B
    logic [15:0] exp_addr [2][MAX_WR];
    logic [15:0] exp_data [2][MAX_WR];
    copp_isa_pkg::pc_t exp_pc [2][MAX_WR];
    // WAIT target that must be reached before this write
    logic exp_wait [2][MAX_WR];
    logic exp_ign_h [2][MAX_WR];
    copp_video_pkg::coord_t exp_tv [2][MAX_WR];
    copp_video_pkg::coord_t exp_th [2][MAX_WR];
    int exp_len [2];
    logic pend_wait, pend_ign_h;
    copp_video_pkg::coord_t pend_tv, pend_th;
    int mode = MODE_NONE;
    int next_mode = MODE_NONE;
    int wr_idx = 0;
    int frame_cnt = 0;
    int cycles = 0;
    logic armed = 1'b0;
    copp_isa_pkg::pc_t base_a, base_b;

    copper i_copper (
        .clk (clk), .copp_reset (copp_reset),
        .reg_wr_i (reg_wr_i), .reg_num_i (reg_num_i), .reg_data_i (reg_data_i),
        .mem_wr_i (mem_wr_i), .mem_addr_i (mem_addr_i), .mem_data_i (mem_data_i),
        .h_count_i (h_count), .v_count_i (v_count),
        .xr_wr_en_o (xr_wr_en_o), .xr_wr_addr_o (xr_wr_addr_o), .xr_wr_data_o (xr_wr_data_o)
    );

    always #4 clk = ~clk;

    // Beam counters wrap per line and per frame
    always @(posedge clk) begin
        if (copp_reset || h_count == copp_video_pkg::H_TOTAL - 11'd1) begin
            h_count <= '0;
            if (copp_reset || v_count == copp_video_pkg::V_TOTAL - 11'd1) begin
                v_count <= '0;
            end else begin
                v_count <= v_count + 11'd1;
            end
        end else begin
            h_count <= h_count + 11'd1;
        end
    end

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("TESTS FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic check_xr_addr(input logic [15:0] got, input logic [15:0] exp);
        if (got !== exp) begin
            stop_run($sformatf("ERR %0t xr_wr_addr_o got %h exp %h", $time, got, exp));
        end
    endtask

    task automatic check_xr_data(input logic [15:0] got, input logic [15:0] exp);
        if (got !== exp) begin
            stop_run($sformatf("ERR %0t xr_wr_data_o got %h exp %h", $time, got, exp));
        end
    endtask

    task automatic check_pc(input copp_isa_pkg::pc_t got, input copp_isa_pkg::pc_t exp);
        if (got !== exp) begin
            stop_run($sformatf("ERR %0t pc got %0d exp %0d", $time, got, exp));
        end
    endtask

    // Two host writes with the even word first
    task automatic put_insn(input copp_isa_pkg::pc_t idx, input logic [15:0] w0,
                            input logic [15:0] w1);
        @(posedge clk);
        mem_wr_i   <= 1'b1;
        mem_addr_i <= {idx, 1'b0};
        mem_data_i <= w0;
        @(posedge clk);
        mem_addr_i <= {idx, 1'b1};
        mem_data_i <= w1;
        @(posedge clk);
        mem_wr_i   <= 1'b0;
    endtask

    // WAIT and SKIP share one layout
    task automatic put_pos(input copp_isa_pkg::pc_t idx, input copp_isa_pkg::opcode_t op,
                           input copp_video_pkg::coord_t tv, input copp_video_pkg::coord_t th,
                           input logic ign_v, input logic ign_h);
        put_insn(idx, {op, 1'b0, tv}, {1'b0, th, 2'b00, ign_h, ign_v});
    endtask

    // Random MOVE that is predicted unless a SKIP passes over it
    task automatic add_move(input int p, inout copp_isa_pkg::pc_t idx, input logic skipped);
        int kind;
        logic [11:0] arg;
        logic [15:0] addr, data;
        logic [15:0] w0;
        kind = int'($urandom % 3);
        arg  = 12'($urandom);
        data = 16'($urandom);
        if (kind == 0) begin
            w0 = {copp_isa_pkg::OP_MOVER, 4'h0, arg[7:0]};
            addr = {8'h00, arg[7:0]};
        end else if (kind == 1) begin
            w0 = {copp_isa_pkg::OP_MOVEF, arg};
            addr = 16'h4000 + {4'h0, arg};
        end else begin
            w0 = {copp_isa_pkg::OP_MOVEP, 4'h0, arg[7:0]};
            addr = 16'h8000 + {8'h00, arg[7:0]};
        end
        put_insn(idx, w0, data);
        idx = idx + copp_isa_pkg::pc_t'(1);
        if (!skipped) begin
            exp_addr[p][exp_len[p]] = addr;
            exp_data[p][exp_len[p]] = data;
            exp_pc[p][exp_len[p]] = idx;
            exp_wait[p][exp_len[p]] = pend_wait;
            exp_ign_h[p][exp_len[p]] = pend_ign_h;
            exp_tv[p][exp_len[p]] = pend_tv;
            exp_th[p][exp_len[p]] = pend_th;
            exp_len[p]++;
            pend_wait = 1'b0;
        end
    endtask

    task automatic build_prog(input int p, input copp_isa_pkg::pc_t base);
        copp_isa_pkg::pc_t idx;
        int n;
        idx = base;
        pend_wait = 1'b0;
        n = 4 + int'($urandom % 3);
        repeat (n) add_move(p, idx, 1'b0);
        // Forward jump over unused memory
        idx = base + copp_isa_pkg::pc_t'(100 + $urandom % 200);
        put_insn(base + copp_isa_pkg::pc_t'(n), {copp_isa_pkg::OP_JMP, 2'b00, idx}, 16'h0000);
        // Unknown opcode works as a no-op
        put_insn(idx, {4'hC, 12'($urandom)}, 16'($urandom));
        idx = idx + copp_isa_pkg::pc_t'(1);
        put_pos(idx, copp_isa_pkg::OP_SKIP, 11'($urandom), 11'($urandom), 1'b1, 1'b1);
        idx = idx + copp_isa_pkg::pc_t'(1);
        add_move(p, idx, 1'b1);
        // Line 2047 is never reached
        put_pos(idx, copp_isa_pkg::OP_SKIP, 11'h7FF, 11'd0, 1'b0, 1'b1);
        idx = idx + copp_isa_pkg::pc_t'(1);
        add_move(p, idx, 1'b0);
        pend_tv = 11'(2 + $urandom % 19);
        pend_th = 11'($urandom % 61);
        pend_ign_h = 1'($urandom);
        put_pos(idx, copp_isa_pkg::OP_WAIT, pend_tv, pend_th, 1'b0, pend_ign_h);
        pend_wait = 1'b1;
        idx = idx + copp_isa_pkg::pc_t'(1);
        repeat (2 + $urandom % 2) add_move(p, idx, 1'b0);
        // Both flags set parks until the next frame
        put_pos(idx, copp_isa_pkg::OP_WAIT, 11'd0, 11'd0, 1'b1, 1'b1);
    endtask

    // Lands just before the restart so a new setting starts a clean frame
    task automatic ctrl_at_frame_end(input int k, input logic en, input copp_isa_pkg::pc_t init,
                                     input int m);
        @(posedge clk);
        while (!(frame_cnt == k && v_count == copp_video_pkg::RESTART_V &&
                 h_count == copp_video_pkg::RESTART_H - 11'd2)) @(posedge clk);
        reg_wr_i   <= 1'b1;
        reg_num_i  <= copp_isa_pkg::XR_COPP_CTRL;
        reg_data_i <= {en, 5'b00000, init};
        next_mode = m;
        @(posedge clk);
        reg_wr_i   <= 1'b0;
    endtask

    // Outputs sampled at the falling edge
    always @(negedge clk) begin
        if (i_copper.i_sequencer.i_copper_properties.err_cnt != 0) begin
            stop_run("an assertion on the sequencer failed");
        end
        if (!copp_reset && xr_wr_en_o && armed) begin
            if (mode == MODE_NONE) stop_run("XR write seen while the copper is disabled");
            if (wr_idx >= exp_len[mode]) stop_run("more XR writes than predicted in a frame");
            check_xr_addr(xr_wr_addr_o, exp_addr[mode][wr_idx]);
            check_xr_data(xr_wr_data_o, exp_data[mode][wr_idx]);
            check_pc(i_copper.i_sequencer.pc, exp_pc[mode][wr_idx]);
            if (exp_wait[mode][wr_idx] && (v_count < exp_tv[mode][wr_idx] ||
                (!exp_ign_h[mode][wr_idx] && h_count < exp_th[mode][wr_idx])))
                stop_run("XR write came before the WAIT position was reached");
            wr_idx++;
        end
        if (!copp_reset && h_count == copp_video_pkg::RESTART_H &&
            v_count == copp_video_pkg::RESTART_V) begin
            if (armed && mode != MODE_NONE && wr_idx != exp_len[mode]) begin
                stop_run($sformatf("frame ended after %0d of %0d XR writes",
                                   wr_idx, exp_len[mode]));
            end
            frame_cnt++;
            mode   = next_mode;
            wr_idx = 0;
            armed  = 1'b1;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > LIMIT) stop_run("timeout, frames did not complete in time");
    end

    initial begin
        void'($urandom(32'h1c36));
        copp_reset = 1'b1;
        reg_wr_i = 1'b0;
        mem_wr_i = 1'b0;
        reg_num_i = '0;
        reg_data_i = '0;
        mem_addr_i = '0;
        mem_data_i = '0;
        exp_len = '{0, 0};
        repeat (3) @(posedge clk);
        copp_reset <= 1'b0;
        base_a = copp_isa_pkg::pc_t'(16 + $urandom % 64);
        base_b = copp_isa_pkg::pc_t'(512 + $urandom % 64);
        build_prog(0, base_a);
        build_prog(1, base_b);
        // Program A for two frames, one frame off, then program B
        ctrl_at_frame_end(0, 1'b1, base_a, 0);
        ctrl_at_frame_end(2, 1'b0, base_b, MODE_NONE);
        ctrl_at_frame_end(3, 1'b1, base_b, 1);
        while (frame_cnt < 6) @(posedge clk);
        @(negedge clk);
        if (i_copper.i_sequencer.i_copper_properties.err_cnt == 0) begin
            $display("TESTS PASSED");
            $finish;
        end else begin
            stop_run("an assertion on the sequencer failed");
        end
    end

endmodule

//--- copper.f
copp_video_pkg.sv
copp_isa_pkg.sv
copp_bank_if.sv
copp_host_port.sv
copp_mem_bank.sv
copp_sequencer.sv
copper.sv
copper_properties.sv
tb_copper.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_copper
FILELIST  ?= copper.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee /dev/stderr | grep -q "TESTS PASSED"

clean:
	rm -rf $(OBJ_DIR)
